/* hw/gf64_lane_mult.sv */
/*
  Goldilocks modular multiplier for one lane
  - Stage 1 full 128-bit product
  - Stage 2 fold of the upper words into a signed partial sum
  - Stage 3 sign and carry correction below 2^64
  Result is congruent to a*phi but not always below PRIME
*/
`timescale 1ns/1ps

module gf64_lane_mult (
  input  logic                           clk,
  input  logic [phi_mult_pkg::MOD_W-1:0] a_i,
  input  logic [phi_mult_pkg::MOD_W-1:0] phi_i,
  output logic [phi_mult_pkg::MOD_W-1:0] z_o
);

  logic [2*phi_mult_pkg::MOD_W-1:0] s1_prod;

  logic [phi_mult_pkg::MOD_W-1:0]   prod_lo;
  logic [phi_mult_pkg::MOD_W/2-1:0] prod_mid;
  logic [phi_mult_pkg::MOD_W/2-1:0] prod_top;
  logic [phi_mult_pkg::MOD_W-1:0]   mid_fold;
  logic [phi_mult_pkg::MOD_W+1:0]   s2_sum; // Bit 65 sign, bit 64 carry

  // ------------------------------
  // Stage 1 : product
  // ------------------------------
  always_ff @(posedge clk) begin
    s1_prod <= a_i * phi_i;
  end

  // ------------------------------
  // Stage 2 : fold
  // ------------------------------
  assign prod_lo  = s1_prod[phi_mult_pkg::MOD_W-1:0];
  assign prod_mid = s1_prod[phi_mult_pkg::MOD_W +: phi_mult_pkg::MOD_W/2];
  assign prod_top = s1_prod[phi_mult_pkg::MOD_W + phi_mult_pkg::MOD_W/2 +: phi_mult_pkg::MOD_W/2];

  // 2^64 = 2^32 - 1 mod p, so mid weighs mid*2^32 - mid
  assign mid_fold = {prod_mid, {(phi_mult_pkg::MOD_W/2){1'b0}}}
                  - {{(phi_mult_pkg::MOD_W/2){1'b0}}, prod_mid};

  // 2^96 = -1 mod p, so top is subtracted
  // Sum lies in [-(2^32-1), 2^65), two's complement in 66 bits
  always_ff @(posedge clk) begin
    s2_sum <= {2'b00, prod_lo}
            + {2'b00, mid_fold}
            - {{(phi_mult_pkg::MOD_W/2 + 2){1'b0}}, prod_top};
  end

  // ------------------------------
  // Stage 3 : correction
  // ------------------------------
  always_ff @(posedge clk) begin
    if (s2_sum[phi_mult_pkg::MOD_W+1]) begin
      // Negative, add p back
      z_o <= s2_sum[phi_mult_pkg::MOD_W-1:0] + phi_mult_pkg::PRIME;
    end else if (s2_sum[phi_mult_pkg::MOD_W]) begin
      // Carry out of 2^64, minus p is plus 2^32-1 modulo 2^64
      z_o <= s2_sum[phi_mult_pkg::MOD_W-1:0] - phi_mult_pkg::PRIME;
    end else begin
      z_o <= s2_sum[phi_mult_pkg::MOD_W-1:0];
    end
  end

endmodule

/* hw/gf64_reduce_out.sv */
/*
  Output reducer
  - Delay line for avail and side matching the lane latency
  - Final subtraction of PRIME on every lane
  - Output register
*/
`timescale 1ns/1ps

module gf64_reduce_out (
  input  logic                                                      clk,
  input  logic                                                      s_rst_n,
  input  logic                                                      avail_i,
  input  logic [phi_mult_pkg::SIDE_W-1:0]                           side_i,
  input  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] lane_data_i,
  output logic                                                      avail_o,
  output logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] data_o,
  output logic [phi_mult_pkg::SIDE_W-1:0]                           side_o
);

  logic [phi_mult_pkg::LANE_LAT-1:0] avail_dly;
  logic [phi_mult_pkg::SIDE_W-1:0]   side_dly [phi_mult_pkg::LANE_LAT];
  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] red_data;

  // ------------------------------
  // Delay line
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_dly <= '0;
    end else begin
      avail_dly[0] <= avail_i;
      for (int i = 1; i < phi_mult_pkg::LANE_LAT; i++) begin
        avail_dly[i] <= avail_dly[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    side_dly[0] <= side_i;
    for (int i = 1; i < phi_mult_pkg::LANE_LAT; i++) begin
      side_dly[i] <= side_dly[i-1];
    end
  end

  // ------------------------------
  // Canonical reduction
  // ------------------------------
  always_comb begin
    for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) begin
      red_data[j] = (lane_data_i[j] >= phi_mult_pkg::PRIME) ?
                    lane_data_i[j] - phi_mult_pkg::PRIME : lane_data_i[j];
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) avail_o <= 1'b0;
    else          avail_o <= avail_dly[phi_mult_pkg::LANE_LAT-1];
  end

  always_ff @(posedge clk) begin
    data_o <= red_data;
    side_o <= side_dly[phi_mult_pkg::LANE_LAT-1]; // Aligned with lane results
  end

endmodule

/* hw/phi_gen.sv */
/*
  Phi row generator
  - Level counter over the interleaved levels
  - Iteration counter stepped on each level wrap
  - Current table row driven to every lane
*/
`timescale 1ns/1ps

module phi_gen (
  input  logic                                                    clk,
  input  logic                                                    s_rst_n,
  input  logic                                                    avail_i,
  output logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] phi_o
);

  logic [phi_mult_pkg::LVL_W-1:0]  lvl_cnt;
  logic [phi_mult_pkg::ITER_W-1:0] iter_cnt;
  logic                            lvl_last;
  logic                            iter_last;

  assign lvl_last  = (lvl_cnt == phi_mult_pkg::LVL_W'(phi_mult_pkg::LVL_NB - 1));
  assign iter_last = (iter_cnt == phi_mult_pkg::ITER_W'(phi_mult_pkg::ITER_NB - 1));

  // ------------------------------
  // Counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      lvl_cnt  <= '0;
      iter_cnt <= '0;
    end else if (avail_i) begin
      if (lvl_last) begin
        lvl_cnt  <= '0;
        iter_cnt <= iter_last ? '0 : iter_cnt + 1'b1; // Wrap after the last row
      end else begin
        lvl_cnt <= lvl_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // Row select
  // ------------------------------
  // Combinational so the row lines up with the vector now at the lanes
  always_comb begin
    for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) begin
      phi_o[j] = phi_mult_pkg::PHI_TABLE[iter_cnt][j];
    end
  end

endmodule

/* hw/phi_mult_pkg.sv */
/*
  Shared constants of the phi multiplication stage
  - Goldilocks prime and field element width
  - Lane, level and iteration counts with their counter widths
  - Side-data width and lane multiplier latency
  - Phi constant table, one row per iteration
*/
package phi_mult_pkg;

  // ------------------------------
  // Field
  // ------------------------------
  localparam int MOD_W = 64;
  localparam logic [MOD_W-1:0] PRIME = 64'hFFFF_FFFF_0000_0001; // 2^64 - 2^32 + 1

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int LANE_NB = 4;
  localparam int ITER_NB = 8;
  localparam int ITER_W  = ($clog2(ITER_NB) == 0) ? 1 : $clog2(ITER_NB);
  localparam int LVL_NB  = 2; // Interleaved levels per phi row
  localparam int LVL_W   = ($clog2(LVL_NB) == 0) ? 1 : $clog2(LVL_NB);
  localparam int SIDE_W  = 8;

  localparam int LANE_LAT = 3; // Product, fold, sign/carry fix

  // ------------------------------
  // Phi table
  // ------------------------------
  // Indexed [iteration][lane], every entry below PRIME.
  // Row 1 holds the powers of the 8th root of unity 2^24.
  localparam logic [MOD_W-1:0] PHI_TABLE [ITER_NB][LANE_NB] = '{
    '{64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001,
      64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001},
    '{64'h0000_0000_0000_0001, 64'h0000_0000_0100_0000,
      64'h0001_0000_0000_0000, 64'h0000_00FF_FFFF_FF00},
    '{64'hFFFF_FFFF_0000_0000, 64'h0000_0001_0000_0000,
      64'hFFFF_FFFE_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF},
    '{64'h1D8A_3F05_6C21_9E47, 64'h7B40_C2D9_0E35_18AF,
      64'hC391_5A6E_44F0_2B1D, 64'h0F6E_9D23_B87A_5C14},
    '{64'h8E12_47B9_D3C0_6A25, 64'h2C57_E1A8_906F_3DB2,
      64'hF0A4_1B7C_5E93_C806, 64'h5937_6DE2_0A18_F4C9},
    '{64'hA6F3_08C1_7D54_E29B, 64'h3E81_B5F0_29C7_4D63,
      64'h64D2_9A37_F105_8BEE, 64'hD718_4C6B_E3A9_0257},
    '{64'h0B9C_F2E4_6187_D35A, 64'hEC26_7031_A8DB_94F1,
      64'h48B5_DE9A_1C62_07F3, 64'h92E0_3B4F_76A1_C588},
    '{64'h713F_A845_D0E9_2C6B, 64'hB54E_0C92_6F17_A3D0,
      64'h27D9_83F6_E42C_B190, 64'hFFFF_FFFE_0000_0002}
  };

endpackage

/* hw/phi_mult_top.sv */
/*
  Phi multiplication stage of the GF64 NTT
  - Input register
  - Phi row generator
  - One Goldilocks multiplier per lane
  - Output reducer with side-data alignment
*/
`timescale 1ns/1ps

module phi_mult_top (
  input  logic                                                      clk,
  input  logic                                                      s_rst_n,
  input  logic                                                      avail_i,
  input  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] data_i,
  input  logic [phi_mult_pkg::SIDE_W-1:0]                           side_i,
  output logic                                                      avail_o,
  output logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] data_o,
  output logic [phi_mult_pkg::SIDE_W-1:0]                           side_o
);

  logic                                                      s0_avail;
  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] s0_data;
  logic [phi_mult_pkg::SIDE_W-1:0]                           s0_side;
  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] phi_row;
  logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] lane_data;

  // ------------------------------
  // Input register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) s0_avail <= 1'b0;
    else          s0_avail <= avail_i;
  end

  always_ff @(posedge clk) begin
    s0_data <= data_i;
    s0_side <= side_i;
  end

  // ------------------------------
  // Phis and lanes
  // ------------------------------
  phi_gen phi_gen_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .avail_i (s0_avail),
    .phi_o   (phi_row)
  );

  for (genvar gen_j = 0; gen_j < phi_mult_pkg::LANE_NB; gen_j++) begin : gen_lane_loop
    gf64_lane_mult lane_mult_i (
      .clk   (clk),
      .a_i   (s0_data[gen_j]),
      .phi_i (phi_row[gen_j]),
      .z_o   (lane_data[gen_j])
    );
  end

  gf64_reduce_out reduce_out_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .avail_i     (s0_avail),
    .side_i      (s0_side),
    .lane_data_i (lane_data),
    .avail_o     (avail_o),
    .data_o      (data_o),
    .side_o      (side_o)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the phi multiplication testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_phi_mult \
  -f verilog.f \
  --Mdir obj_dir

sim_out=$(./obj_dir/Vtb_phi_mult)
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* tests/tb_clk_gen.sv */
/*
  Testbench clock and reset
  - Free-running clock
  - Synchronous active-low reset held for a number of cycles
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD  = 100,
  parameter int RST_CYC = 16
) (
  output logic clk_o,
  output logic s_rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD/2) clk_o = ~clk_o;
  end

  initial begin
    s_rst_n_o = 1'b0;
    repeat (RST_CYC) @(posedge clk_o);
    #1 s_rst_n_o = 1'b1; // Released off the edge
  end

endmodule

/* tests/tb_phi_mult.sv */
/*
  Testbench for the phi multiplication stage
  - LCG stimulus: random vectors with gaps, back-to-back burst, edge operands
  - Reference model of the phi rule feeding an expected-vector queue
  - Output monitor with data, side and latency checks
  - Cycle timeout and closing report
*/
`timescale 1ns/1ps

module tb_phi_mult;

  typedef logic [phi_mult_pkg::LANE_NB-1:0][phi_mult_pkg::MOD_W-1:0] vec_t;

  localparam int RST_CYC     = 16;
  localparam int N_RAND      = 64; // Whole phi table sweeps, burst starts at iteration 0
  localparam int MAX_GAP     = 3;
  localparam int BURST_NB    = 2 * phi_mult_pkg::LVL_NB * phi_mult_pkg::ITER_NB + 3;
  localparam int EDGE_NB     = 2 * phi_mult_pkg::LVL_NB * phi_mult_pkg::ITER_NB;
  localparam int DRAIN_IDLE  = 10;
  localparam int DUT_LAT     = phi_mult_pkg::LANE_LAT + 2; // Input and output registers
  localparam int STIM_CYC    = N_RAND * (MAX_GAP + 1) + BURST_NB + EDGE_NB + DRAIN_IDLE;
  localparam int TIMEOUT_CYC = STIM_CYC + RST_CYC + DUT_LAT + 20;

  // Operands that hit the fold and the final subtraction
  localparam logic [63:0] EDGE_VAL [8] = '{
    64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001,
    64'h0001_0000_0000_0000, phi_mult_pkg::PRIME - 64'd1,
    phi_mult_pkg::PRIME - 64'd2, 64'h0000_0001_0000_0000,
    64'h0000_0000_FFFF_FFFF, 64'h0000_0001_0000_0001
  };

  logic                            clk;
  logic                            s_rst_n;
  logic                            avail_i;
  vec_t                            data_i;
  logic [phi_mult_pkg::SIDE_W-1:0] side_i;
  logic                            avail_o;
  vec_t                            data_o;
  logic [phi_mult_pkg::SIDE_W-1:0] side_o;

  logic [31:0] lcg_state;
  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          vec_cnt   = 0;
  int          cycle_cnt = 0;

  vec_t                            exp_q  [$];
  logic [phi_mult_pkg::SIDE_W-1:0] side_q [$];
  int                              cyc_q  [$];

  tb_clk_gen #(.PERIOD(100), .RST_CYC(RST_CYC)) clk_gen_i (
    .clk_o     (clk),
    .s_rst_n_o (s_rst_n)
  );

  phi_mult_top dut_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .avail_i (avail_i),
    .data_i  (data_i),
    .side_i  (side_i),
    .avail_o (avail_o),
    .data_o  (data_o),
    .side_o  (side_o)
  );

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand_elem();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] val;
    hi  = lcg_next();
    lo  = lcg_next();
    val = {hi, lo};
    if (val >= phi_mult_pkg::PRIME) begin
      hi  = lcg_next();
      val = EDGE_VAL[hi[31:29]]; // Keep inputs canonical
    end
    return val;
  endfunction

  // Model the phi rule, queue the result, then drive one vector for one cycle
  task automatic send_vec(input vec_t vec, input logic [phi_mult_pkg::SIDE_W-1:0] side);
    logic [phi_mult_pkg::ITER_W-1:0] iter;
    logic [127:0]                    prod;
    vec_t                            exp_vec;
    iter = phi_mult_pkg::ITER_W'((vec_cnt / phi_mult_pkg::LVL_NB) % phi_mult_pkg::ITER_NB);
    for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) begin
      prod = {64'h0, vec[j]} * {64'h0, phi_mult_pkg::PHI_TABLE[iter][j]};
      prod = prod % {64'h0, phi_mult_pkg::PRIME};
      exp_vec[j] = prod[63:0];
    end
    exp_q.push_back(exp_vec);
    side_q.push_back(side);
    cyc_q.push_back(cycle_cnt + DUT_LAT);
    vec_cnt++;
    avail_i = 1'b1;
    data_i  = vec;
    side_i  = side;
    @(posedge clk);
    #1;
    avail_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    avail_i = 1'b0;
    for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) begin
      data_i[j] = rand_elem(); // Junk that must be ignored
    end
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    vec_t        vec;
    logic [31:0] r;
    avail_i   = 1'b0;
    data_i    = '0;
    side_i    = '0;
    lcg_state = 32'h6826;
    while (s_rst_n !== 1'b1) @(posedge clk);
    #1;

    // Random vectors, gaps of 0 to MAX_GAP cycles
    for (int i = 0; i < N_RAND; i++) begin
      for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) vec[j] = rand_elem();
      r = lcg_next();
      send_vec(vec, r[31:24]);
      idle_cycles(int'(r[23:22]));
    end

    // Back-to-back across every iteration and the wrap
    for (int i = 0; i < BURST_NB; i++) begin
      for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) vec[j] = rand_elem();
      send_vec(vec, phi_mult_pkg::SIDE_W'(i));
    end

    for (int i = 0; i < EDGE_NB; i++) begin
      for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) vec[j] = EDGE_VAL[3'(i + j)];
      r = lcg_next();
      send_vec(vec, r[31:24]);
    end

    idle_cycles(DRAIN_IDLE); // Drain the pipeline, catch any stray avail_o

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d vectors never produced avail_o", exp_q.size());
    end
    $display("Checked %0d of %0d vectors, %0d errors", chk_cnt, vec_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt == vec_cnt && exp_q.size() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // ------------------------------
  // Output monitor
  // ------------------------------
  always @(negedge clk) begin
    vec_t                            exp_vec;
    logic [phi_mult_pkg::SIDE_W-1:0] exp_side;
    int                              exp_cyc;
    if (cycle_cnt > 0) begin
      if (avail_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("avail_o went high at %0d ns with no vector in flight", $time);
        end else begin
          exp_vec  = exp_q.pop_front();
          exp_side = side_q.pop_front();
          exp_cyc  = cyc_q.pop_front();
          chk_cnt++;
          if (exp_cyc != cycle_cnt) begin
            err_cnt++;
            $display("error at %0d ns: avail_o cycle expected %0d actual %0d",
                     $time, exp_cyc, cycle_cnt);
          end
          for (int j = 0; j < phi_mult_pkg::LANE_NB; j++) begin
            if (data_o[j] !== exp_vec[j]) begin
              err_cnt++;
              $display("error at %0d ns: data_o[%0d] expected %h actual %h",
                       $time, j, exp_vec[j], data_o[j]);
            end
          end
          if (side_o !== exp_side) begin
            err_cnt++;
            $display("error at %0d ns: side_o expected %h actual %h", $time, exp_side, side_o);
          end
        end
      end else if (avail_o !== 1'b0) begin
        err_cnt++;
        $display("avail_o is unknown at %0d ns", $time);
      end
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the stimulus or the drain never finished", cycle_cnt);
      $display("Checked %0d of %0d vectors, %0d errors", chk_cnt, vec_cnt, err_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

/* verilog.f */
hw/phi_mult_pkg.sv
hw/phi_gen.sv
hw/gf64_lane_mult.sv
hw/gf64_reduce_out.sv
hw/phi_mult_top.sv
tests/tb_clk_gen.sv
tests/tb_phi_mult.sv
